// ==== src/bus_types_pkg.sv ====
`default_nettype none

package bus_types_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int LED_COUNT = 10;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Address fields
	typedef logic [3:0] region_t;
	typedef logic [3:0] far_device_t;
	typedef logic [2:0] reg_index_t;

	typedef logic [LED_COUNT-1:0] leds_t;

	// ==================================================
	// Bus owner and state machines
	// ==================================================
	typedef enum logic [1:0] {
		SOURCE_NONE = 2'd0,
		SOURCE_INSTRUCTION = 2'd1,
		SOURCE_DATA = 2'd2
	} bus_source_t;

	typedef enum logic [1:0] {ACCESS_IDLE, ACCESS_ISSUE, ACCESS_WAIT} access_state_t;
	typedef enum logic [1:0] {BRIDGE_IDLE, BRIDGE_FAR, BRIDGE_RESPOND} bridge_state_t;

endpackage

`default_nettype wire

// ==== src/memory_map_pkg.sv ====
`default_nettype none

package memory_map_pkg;

	// ==================================================
	// Main regions from address bits 31 to 28
	// ==================================================
	localparam bus_types_pkg::region_t REGION_RAM = 4'h2;
	localparam bus_types_pkg::region_t REGION_BRIDGE = 4'h5;

	// ==================================================
	// Far devices behind the bridge
	// ==================================================

	// Selected by address bits 27 to 24
	localparam bus_types_pkg::far_device_t FAR_SYSREG = 4'h9;

	// System register indices from address bits 4 to 2
	localparam bus_types_pkg::reg_index_t SYSREG_DEVICE_ID = 3'd0;
	localparam bus_types_pkg::reg_index_t SYSREG_LEDS = 3'd1;
	localparam bus_types_pkg::reg_index_t SYSREG_SCRATCH = 3'd2;

endpackage

`default_nettype wire

// ==== src/bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
	import bus_types_pkg::*;

	// Held by the master until ready
	logic request;
	logic rw;
	addr_t address;
	data_t wdata;

	// Rdata valid only in the ready cycle
	data_t rdata;
	logic ready;

	modport master (
		output request, rw, address, wdata,
		input rdata, ready
	);

	modport slave (
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

`default_nettype wire

// ==== src/bus_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_access (
	input wire clock,
	input wire i_rst_n,

	// Instruction port, read only
	input wire i_ibus_request,
	input wire bus_types_pkg::addr_t i_ibus_address,
	output bus_types_pkg::data_t o_ibus_rdata,
	output logic o_ibus_ready,

	// Data port
	input wire i_dbus_request,
	input wire i_dbus_rw,
	input wire bus_types_pkg::addr_t i_dbus_address,
	input wire bus_types_pkg::data_t i_dbus_wdata,
	output bus_types_pkg::data_t o_dbus_rdata,
	output logic o_dbus_ready,

	bus_if.master bus,
	output bus_types_pkg::bus_source_t o_owner
);
	import bus_types_pkg::*;

	access_state_t state;
	data_t read_data;
	logic grant_data;
	logic grant_instr;

	// Data port wins a tie
	assign grant_data = (state == ACCESS_IDLE) && i_dbus_request;
	assign grant_instr = (state == ACCESS_IDLE) && i_ibus_request && !i_dbus_request;

	// Only the owner sees ready so one shared register is enough
	assign o_ibus_rdata = read_data;
	assign o_dbus_rdata = read_data;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ACCESS_IDLE;
			bus.request <= 1'b0;
			o_owner <= SOURCE_NONE;
			o_ibus_ready <= 1'b0;
			o_dbus_ready <= 1'b0;
		end else begin
			case (state)
				ACCESS_IDLE: begin
					if (grant_data) begin
						bus.request <= 1'b1;
						o_owner <= SOURCE_DATA;
						state <= ACCESS_ISSUE;
					end else if (grant_instr) begin
						bus.request <= 1'b1;
						o_owner <= SOURCE_INSTRUCTION;
						state <= ACCESS_ISSUE;
					end
				end
				ACCESS_ISSUE: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_ibus_ready <= (o_owner == SOURCE_INSTRUCTION);
						o_dbus_ready <= (o_owner == SOURCE_DATA);
						state <= ACCESS_WAIT;
					end
				end
				ACCESS_WAIT: begin
					// Port sees its ready here and drops or renews its request
					o_ibus_ready <= 1'b0;
					o_dbus_ready <= 1'b0;
					o_owner <= SOURCE_NONE;
					state <= ACCESS_IDLE;
				end
				default: state <= ACCESS_IDLE;
			endcase
		end
	end

	// Access fields and returned data
	always_ff @(posedge clock) begin
		if (grant_data) begin
			bus.rw <= i_dbus_rw;
			bus.address <= i_dbus_address;
			bus.wdata <= i_dbus_wdata;
		end else if (grant_instr) begin
			bus.rw <= 1'b0;
			bus.address <= i_ibus_address;
		end
		if (state == ACCESS_ISSUE && bus.ready)
			read_data <= bus.rdata;
	end

endmodule

`default_nettype wire

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input wire clock,
	input wire i_rst_n,
	bus_if.slave bus,
	bus_if.master ram,
	bus_if.master bridge,
	input wire bus_types_pkg::bus_source_t i_owner,
	output logic o_bus_fault,
	output bus_types_pkg::addr_t o_fault_address,
	output bus_types_pkg::bus_source_t o_fault_source
);
	import bus_types_pkg::*;
	import memory_map_pkg::*;

	region_t region;
	addr_t local_address;
	logic ram_select;
	logic bridge_select;
	logic fault_start;

	assign region = bus.address[31:28];
	assign ram_select = (region == REGION_RAM);
	assign bridge_select = (region == REGION_BRIDGE);
	assign local_address = {4'h0, bus.address[27:0]};

	// ==================================================
	// Forward requests to the selected region
	// ==================================================
	assign ram.request = bus.request && ram_select;
	assign ram.rw = bus.rw;
	assign ram.address = local_address;
	assign ram.wdata = bus.wdata;

	assign bridge.request = bus.request && bridge_select;
	assign bridge.rw = bus.rw;
	assign bridge.address = local_address;
	assign bridge.wdata = bus.wdata;

	// Unmapped regions answer with zero from the fault pulse
	always_comb begin
		if (ram_select) begin
			bus.rdata = ram.rdata;
			bus.ready = ram.ready;
		end else if (bridge_select) begin
			bus.rdata = bridge.rdata;
			bus.ready = bridge.ready;
		end else begin
			bus.rdata = '0;
			bus.ready = o_bus_fault;
		end
	end

	// ==================================================
	// Fault diagnostics
	// ==================================================
	assign fault_start = bus.request && !ram_select && !bridge_select && !o_bus_fault;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_fault <= 1'b0;
			o_fault_address <= '0;
			o_fault_source <= SOURCE_NONE;
		end else begin
			o_bus_fault <= fault_start;
			if (fault_start) begin
				o_fault_address <= bus.address;
				o_fault_source <= i_owner;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/block_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_memory #(
	parameter int RAM_WORDS = 1024
) (
	input wire clock,
	bus_if.slave bus
);
	import bus_types_pkg::*;

	localparam int INDEX_WIDTH = $clog2(RAM_WORDS);

	data_t memory [RAM_WORDS];
	logic [INDEX_WIDTH-1:0] index;
	logic access;

	// Word index wraps at RAM_WORDS
	assign index = INDEX_WIDTH'(bus.address[31:2] % RAM_WORDS);

	// Request is still high in the ready cycle
	assign access = bus.request && !bus.ready;

	always_ff @(posedge clock) begin
		bus.ready <= access;
		if (access) begin
			if (bus.rw)
				memory[index] <= bus.wdata;
			else
				bus.rdata <= memory[index];
		end
	end

endmodule

`default_nettype wire

// ==== src/far_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module far_bridge (
	input wire clock,
	input wire i_rst_n,
	bus_if.slave near,
	bus_if.master far
);
	import bus_types_pkg::*;
	import memory_map_pkg::*;

	bridge_state_t state;
	far_device_t device;
	logic start_far;
	logic answer_zero;

	assign device = near.address[27:24];
	assign start_far = (state == BRIDGE_IDLE) && near.request && (device == FAR_SYSREG);
	assign answer_zero = (state == BRIDGE_IDLE) && near.request && (device != FAR_SYSREG);

	// ==================================================
	// Bridge FSM
	// ==================================================
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= BRIDGE_IDLE;
			far.request <= 1'b0;
			near.ready <= 1'b0;
		end else begin
			case (state)
				BRIDGE_IDLE: begin
					if (start_far) begin
						far.request <= 1'b1;
						state <= BRIDGE_FAR;
					end else if (answer_zero) begin
						near.ready <= 1'b1;
						state <= BRIDGE_RESPOND;
					end
				end
				BRIDGE_FAR: begin
					if (far.ready) begin
						far.request <= 1'b0;
						near.ready <= 1'b1;
						state <= BRIDGE_RESPOND;
					end
				end
				BRIDGE_RESPOND: begin
					// Near request drops while ready is high
					near.ready <= 1'b0;
					state <= BRIDGE_IDLE;
				end
				default: state <= BRIDGE_IDLE;
			endcase
		end
	end

	// Far access fields and near read data
	always_ff @(posedge clock) begin
		if (start_far) begin
			far.rw <= near.rw;
			far.address <= near.address;
			far.wdata <= near.wdata;
		end
		if (answer_zero)
			near.rdata <= '0;
		else if (state == BRIDGE_FAR && far.ready)
			near.rdata <= far.rdata;
	end

endmodule

`default_nettype wire

// ==== src/system_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_registers #(
	parameter bus_types_pkg::data_t DEVICE_ID = 32'd1
) (
	input wire clock,
	input wire i_rst_n,
	bus_if.slave bus,
	output bus_types_pkg::leds_t o_leds
);
	import bus_types_pkg::*;
	import memory_map_pkg::*;

	reg_index_t index;
	data_t scratch;
	logic access;

	assign index = bus.address[4:2];
	assign access = bus.request && !bus.ready;

	// Writes to the identifier and unknown indices fall through
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bus.ready <= 1'b0;
			o_leds <= '0;
			scratch <= '0;
		end else begin
			bus.ready <= access;
			if (access && bus.rw) begin
				case (index)
					SYSREG_LEDS: o_leds <= leds_t'(bus.wdata);
					SYSREG_SCRATCH: scratch <= bus.wdata;
					default: ;
				endcase
			end
		end
	end

	// Read mux
	always_ff @(posedge clock) begin
		if (access && !bus.rw) begin
			case (index)
				SYSREG_DEVICE_ID: bus.rdata <= DEVICE_ID;
				SYSREG_LEDS: bus.rdata <= data_t'(o_leds);
				SYSREG_SCRATCH: bus.rdata <= scratch;
				default: bus.rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int RAM_WORDS = 1024,
	parameter bus_types_pkg::data_t DEVICE_ID = 32'd1
) (
	input wire clock,
	input wire i_rst_n,

	input wire i_ibus_request,
	input wire bus_types_pkg::addr_t i_ibus_address,
	output bus_types_pkg::data_t o_ibus_rdata,
	output logic o_ibus_ready,

	input wire i_dbus_request,
	input wire i_dbus_rw,
	input wire bus_types_pkg::addr_t i_dbus_address,
	input wire bus_types_pkg::data_t i_dbus_wdata,
	output bus_types_pkg::data_t o_dbus_rdata,
	output logic o_dbus_ready,

	output bus_types_pkg::leds_t o_leds,

	// Fault diagnostics
	output logic o_bus_fault,
	output bus_types_pkg::addr_t o_fault_address,
	output bus_types_pkg::bus_source_t o_fault_source
);
	import bus_types_pkg::*;

	bus_if main_bus();
	bus_if ram_bus();
	bus_if bridge_bus();
	bus_if far_bus();

	bus_source_t owner;

	// ==================================================
	// Near side
	// ==================================================
	bus_access bus_access_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ibus_request(i_ibus_request),
		.i_ibus_address(i_ibus_address),
		.o_ibus_rdata(o_ibus_rdata),
		.o_ibus_ready(o_ibus_ready),
		.i_dbus_request(i_dbus_request),
		.i_dbus_rw(i_dbus_rw),
		.i_dbus_address(i_dbus_address),
		.i_dbus_wdata(i_dbus_wdata),
		.o_dbus_rdata(o_dbus_rdata),
		.o_dbus_ready(o_dbus_ready),
		.bus(main_bus.master),
		.o_owner(owner)
	);

	bus_decoder bus_decoder_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.bus(main_bus.slave),
		.ram(ram_bus.master),
		.bridge(bridge_bus.master),
		.i_owner(owner),
		.o_bus_fault(o_bus_fault),
		.o_fault_address(o_fault_address),
		.o_fault_source(o_fault_source)
	);

	block_memory #(
		.RAM_WORDS(RAM_WORDS)
	) block_memory_inst (
		.clock(clock),
		.bus(ram_bus.slave)
	);

	// ==================================================
	// Far side
	// ==================================================
	far_bridge far_bridge_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.near(bridge_bus.slave),
		.far(far_bus.master)
	);

	system_registers #(
		.DEVICE_ID(DEVICE_ID)
	) system_registers_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.bus(far_bus.slave),
		.o_leds(o_leds)
	);

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter real PERIOD_NS = 4.0,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
	end

	// Release on a rising edge after the reset cycles
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
	import bus_types_pkg::*;
	import memory_map_pkg::*;

	localparam int RAM_WORDS = 512;
	localparam data_t DEVICE_ID = 32'h1234_0001;
	localparam int TEST_WORDS = 16;
	// About 150 accesses of at most 8 cycles each plus a wide margin
	localparam int CYCLE_LIMIT = 4000;

	typedef struct packed {
		logic is_read;
		data_t data;
		logic fault;
		addr_t address;
		bus_source_t source;
	} expect_t;

	logic clock;
	logic rst_n;
	logic i_ibus_request;
	addr_t i_ibus_address;
	data_t o_ibus_rdata;
	logic o_ibus_ready;
	logic i_dbus_request;
	logic i_dbus_rw;
	addr_t i_dbus_address;
	data_t i_dbus_wdata;
	data_t o_dbus_rdata;
	logic o_dbus_ready;
	leds_t o_leds;
	logic o_bus_fault;
	addr_t o_fault_address;
	bus_source_t o_fault_source;

	// Reference model state
	data_t ref_ram [RAM_WORDS];
	leds_t ref_leds = '0;
	data_t ref_scratch = '0;

	expect_t dbus_expect[$];
	expect_t ibus_expect[$];
	logic [31:0] lfsr_state = 32'h3eb9_3cd9;
	int cycle_count = 0;
	int fault_pulses = 0;
	int fault_cycle = 0;
	int dbus_done_cycle = 0;
	int ibus_done_cycle = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int tests_failed = 0;
	int test_start_errors = 0;
	string test_name;

	clock_gen #(
		.PERIOD_NS(4.0),
		.RESET_CYCLES(4)
	) clock_gen_inst (
		.o_clock(clock),
		.o_rst_n(rst_n)
	);

	soc_top #(
		.RAM_WORDS(RAM_WORDS),
		.DEVICE_ID(DEVICE_ID)
	) soc_top_inst (
		.clock(clock),
		.i_rst_n(rst_n),
		.i_ibus_request(i_ibus_request),
		.i_ibus_address(i_ibus_address),
		.o_ibus_rdata(o_ibus_rdata),
		.o_ibus_ready(o_ibus_ready),
		.i_dbus_request(i_dbus_request),
		.i_dbus_rw(i_dbus_rw),
		.i_dbus_address(i_dbus_address),
		.i_dbus_wdata(i_dbus_wdata),
		.o_dbus_rdata(o_dbus_rdata),
		.o_dbus_ready(o_dbus_ready),
		.o_leds(o_leds),
		.o_bus_fault(o_bus_fault),
		.o_fault_address(o_fault_address),
		.o_fault_source(o_fault_source)
	);

	// ==================================================
	// Random numbers
	// ==================================================
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] draw_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Random alias of a RAM word with don't care high offset bits
	function automatic addr_t ram_address(input int word);
		logic [31:0] offset;
		offset = draw_bits(26);
		offset = offset - (offset % RAM_WORDS) + word;
		return {REGION_RAM, offset[25:0], 2'b00};
	endfunction

	function automatic addr_t unmapped_address();
		region_t region;
		logic [31:0] offset;
		region = REGION_RAM;
		while (region == REGION_RAM || region == REGION_BRIDGE)
			region = region_t'(draw_bits(4));
		offset = draw_bits(26);
		return {region, offset[25:0], 2'b00};
	endfunction

	function automatic addr_t far_unmapped_address();
		far_device_t device;
		logic [31:0] offset;
		device = FAR_SYSREG;
		while (device == FAR_SYSREG)
			device = far_device_t'(draw_bits(4));
		offset = draw_bits(22);
		return {REGION_BRIDGE, device, offset[21:0], 2'b00};
	endfunction

	function automatic addr_t sysreg_address(input reg_index_t index);
		return {REGION_BRIDGE, FAR_SYSREG, 19'h0, index, 2'b00};
	endfunction

	// ==================================================
	// Reference model
	// ==================================================
	function automatic int ram_word(input addr_t address);
		return int'(address[27:2] % RAM_WORDS);
	endfunction

	function automatic logic is_unmapped(input addr_t address);
		return address[31:28] != REGION_RAM && address[31:28] != REGION_BRIDGE;
	endfunction

	function automatic data_t expected_read(input addr_t address);
		data_t result;
		result = '0;
		if (address[31:28] == REGION_RAM) begin
			result = ref_ram[ram_word(address)];
		end else if (address[31:28] == REGION_BRIDGE && address[27:24] == FAR_SYSREG) begin
			case (reg_index_t'(address[4:2]))
				SYSREG_DEVICE_ID: result = DEVICE_ID;
				SYSREG_LEDS: result = data_t'(ref_leds);
				SYSREG_SCRATCH: result = ref_scratch;
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	function automatic void apply_write(input addr_t address, input data_t wdata);
		if (address[31:28] == REGION_RAM) begin
			ref_ram[ram_word(address)] = wdata;
		end else if (address[31:28] == REGION_BRIDGE && address[27:24] == FAR_SYSREG) begin
			if (reg_index_t'(address[4:2]) == SYSREG_LEDS)
				ref_leds = leds_t'(wdata);
			else if (reg_index_t'(address[4:2]) == SYSREG_SCRATCH)
				ref_scratch = wdata;
		end
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic report_failure(input string message);
		error_count++;
		$display("%s", message);
	endtask

	task automatic compare_data(input string name, input data_t got, input data_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic compare_leds(input string name, input leds_t got, input leds_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %s = 0x%03h, expected 0x%03h", name, got, expected);
		end
	endtask

	task automatic compare_address(input string name, input addr_t got, input addr_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic compare_source(input string name, input bus_source_t got,
			input bus_source_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %s = 0x%01h, expected 0x%01h", name, got, expected);
		end
	endtask

	task automatic check_completion(input string name, input expect_t entry, input data_t rdata);
		if (entry.is_read)
			compare_data(name, rdata, entry.data);
		if (entry.fault) begin
			if (fault_pulses != 1)
				report_failure($sformatf("Bus fault pulsed %0d times for the access to 0x%08h",
					fault_pulses, entry.address));
			else if (fault_cycle != cycle_count - 1)
				report_failure($sformatf("Bus fault off its ready cycle for the access to 0x%08h",
					entry.address));
			compare_address("o_fault_address", o_fault_address, entry.address);
			compare_source("o_fault_source", o_fault_source, entry.source);
		end else if (fault_pulses != 0) begin
			report_failure($sformatf("Bus fault pulsed for the mapped access to 0x%08h",
				entry.address));
		end
		fault_pulses = 0;
	endtask

	// Every port ready is checked against the queued expectation
	always @(posedge clock) begin
		if (o_bus_fault) begin
			fault_pulses++;
			fault_cycle = cycle_count;
		end
		if (o_dbus_ready) begin
			dbus_done_cycle = cycle_count;
			if (dbus_expect.size() == 0)
				report_failure("Data port gave ready with no access pending");
			else
				check_completion("o_dbus_rdata", dbus_expect.pop_front(), o_dbus_rdata);
		end
		if (o_ibus_ready) begin
			ibus_done_cycle = cycle_count;
			if (ibus_expect.size() == 0)
				report_failure("Instruction port gave ready with no access pending");
			else
				check_completion("o_ibus_rdata", ibus_expect.pop_front(), o_ibus_rdata);
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	// ==================================================
	// Port drivers
	// ==================================================
	task automatic data_access(input logic rw, input addr_t address, input data_t wdata);
		expect_t entry;
		entry.is_read = !rw;
		entry.data = rw ? '0 : expected_read(address);
		entry.fault = is_unmapped(address);
		entry.address = address;
		entry.source = SOURCE_DATA;
		if (rw)
			apply_write(address, wdata);
		dbus_expect.push_back(entry);
		@(posedge clock);
		i_dbus_request <= 1'b1;
		i_dbus_rw <= rw;
		i_dbus_address <= address;
		i_dbus_wdata <= wdata;
		@(posedge clock);
		while (!o_dbus_ready)
			@(posedge clock);
		i_dbus_request <= 1'b0;
	endtask

	task automatic instr_access(input addr_t address);
		expect_t entry;
		entry.is_read = 1'b1;
		entry.data = expected_read(address);
		entry.fault = is_unmapped(address);
		entry.address = address;
		entry.source = SOURCE_INSTRUCTION;
		ibus_expect.push_back(entry);
		@(posedge clock);
		i_ibus_request <= 1'b1;
		i_ibus_address <= address;
		@(posedge clock);
		while (!o_ibus_ready)
			@(posedge clock);
		i_ibus_request <= 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_count++;
		test_name = name;
		test_start_errors = error_count;
	endtask

	task automatic end_test();
		int errors;
		@(posedge clock);
		if (dbus_expect.size() != 0 || ibus_expect.size() != 0)
			report_failure("Accesses were still pending at the end of the test");
		errors = error_count - test_start_errors;
		if (errors == 0) begin
			$display("Test %0d, %s: passed", test_count, test_name);
		end else begin
			tests_failed++;
			$display("Test %0d, %s: failed with %0d errors", test_count, test_name, errors);
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		addr_t address;
		addr_t second_address;
		data_t data;
		int word;
		i_ibus_request <= 1'b0;
		i_ibus_address <= '0;
		i_dbus_request <= 1'b0;
		i_dbus_rw <= 1'b0;
		i_dbus_address <= '0;
		i_dbus_wdata <= '0;
		wait (rst_n === 1'b1);
		@(posedge clock);

		begin_test("RAM writes and reads through the data port");
		for (int w = 0; w < TEST_WORDS; w++) begin
			address = ram_address(w);
			data = draw_bits(32);
			data_access(1'b1, address, data);
		end
		for (int n = 0; n < 40; n++) begin
			word = int'(draw_bits(4));
			address = ram_address(word);
			data = draw_bits(32);
			data_access(1'b1, address, data);
		end
		for (int w = 0; w < TEST_WORDS; w++) begin
			address = ram_address(w);
			data_access(1'b0, address, '0);
		end
		end_test();

		begin_test("Instruction port reads of RAM");
		for (int w = 0; w < TEST_WORDS; w++)
			instr_access(ram_address(w));
		for (int n = 0; n < 4; n++) begin
			word = int'(draw_bits(4));
			address = ram_address(word);
			data = draw_bits(32);
			data_access(1'b1, address, data);
			instr_access(ram_address(word));
		end
		end_test();

		begin_test("System registers behind the bridge");
		for (int n = 0; n < 2; n++) begin
			data = draw_bits(32);
			data_access(1'b1, sysreg_address(SYSREG_LEDS), data);
			compare_leds("o_leds", o_leds, ref_leds);
			data_access(1'b0, sysreg_address(SYSREG_LEDS), '0);
		end
		data = draw_bits(32);
		data_access(1'b1, sysreg_address(SYSREG_SCRATCH), data);
		data_access(1'b0, sysreg_address(SYSREG_SCRATCH), '0);
		data_access(1'b0, sysreg_address(SYSREG_DEVICE_ID), '0);
		data = draw_bits(32);
		data_access(1'b1, sysreg_address(SYSREG_DEVICE_ID), data);
		data_access(1'b0, sysreg_address(SYSREG_DEVICE_ID), '0);
		// Unknown index takes no write and reads zero
		data = draw_bits(32);
		data_access(1'b1, sysreg_address(3'd5), data);
		data_access(1'b0, sysreg_address(3'd5), '0);
		compare_leds("o_leds", o_leds, ref_leds);
		end_test();

		begin_test("Unmapped regions and far devices");
		data_access(1'b0, unmapped_address(), '0);
		address = unmapped_address();
		data = draw_bits(32);
		data_access(1'b1, address, data);
		instr_access(unmapped_address());
		data_access(1'b0, far_unmapped_address(), '0);
		address = far_unmapped_address();
		data = draw_bits(32);
		data_access(1'b1, address, data);
		instr_access(far_unmapped_address());
		end_test();

		begin_test("Simultaneous requests on both ports");
		for (int round = 0; round < 5; round++) begin
			if (round == 4)
				address = sysreg_address(SYSREG_SCRATCH);
			else
				address = ram_address(round);
			data = draw_bits(32);
			second_address = ram_address(round + 8);
			fork
				data_access(round % 2 == 0 && round != 4, address, data);
				instr_access(second_address);
			join
			@(posedge clock);
			if (dbus_done_cycle >= ibus_done_cycle)
				report_failure("Instruction port finished before the data port");
		end
		end_test();

		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
			test_count, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/bus_types_pkg.sv
src/memory_map_pkg.sv
src/bus_if.sv
src/bus_access.sv
src/bus_decoder.sv
src/block_memory.sv
src/far_bridge.sv
src/system_registers.sv
src/soc_top.sv
verification/clock_gen.sv
verification/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - src/bus_types_pkg.sv
  - src/memory_map_pkg.sv
  - src/bus_if.sv
  - src/bus_access.sv
  - src/bus_decoder.sv
  - src/block_memory.sv
  - src/far_bridge.sv
  - src/system_registers.sv
  - src/soc_top.sv
  - target: simulation
    files:
      - verification/clock_gen.sv
      - verification/tb_soc.sv
